// ==== build.f ====
+incdir+include
design/cache_pkg.sv
design/cache_setup.sv
design/cache_memory.sv
design/cache_hit.sv
design/cache_core.sv
verification/cache_clk_gen.sv
verification/cache_assertions.sv
verification/cache_tb.sv

// ==== design/cache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_core
  import cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stall_i,
  input  logic        flush_i,
  input  cache_req_t  req_i,
  input  logic        fill_i,
  input  cache_adr_u  fill_adr_i,
  input  cache_word_t fill_data_i,
  output cache_rsp_t  rsp_o
);

  // Setup stage outputs
  cache_req_t stage_req;
  cache_idx_t idx;
  cache_tag_t core_tag;

  // Memory read-out of each way
  cache_line_t [`CACHE_WAYS-1:0] lines;

  // Write-hit and LRU update from the hit stage
  logic        wr_en;
  cache_way_t  wr_way;
  cache_idx_t  wr_idx;
  cache_word_t wr_data;
  logic        touch_en;
  cache_way_t  touch_way;

  //////////////////////////////////////////////////
  // Address setup
  //////////////////////////////////////////////////

  cache_setup u_setup (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .req_i      (req_i),
    .req_o      (stage_req),
    .idx_o      (idx),
    .core_tag_o (core_tag)
  );

  // Tag, valid, LRU and data arrays
  cache_memory u_memory (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .idx_i       (idx),
    .lines_o     (lines),
    .lru_way_o   (),
    .fill_i      (fill_i),
    .fill_adr_i  (fill_adr_i),
    .fill_data_i (fill_data_i),
    .wr_en_i     (wr_en),
    .wr_way_i    (wr_way),
    .wr_idx_i    (wr_idx),
    .wr_data_i   (wr_data),
    .touch_en_i  (touch_en),
    .touch_way_i (touch_way)
  );

  // Compare, respond, update
  cache_hit u_hit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .req_i       (stage_req),
    .core_tag_i  (core_tag),
    .lines_i     (lines),
    .rsp_o       (rsp_o),
    .wr_en_o     (wr_en),
    .wr_way_o    (wr_way),
    .wr_idx_o    (wr_idx),
    .wr_data_o   (wr_data),
    .touch_en_o  (touch_en),
    .touch_way_o (touch_way)
  );

endmodule

`default_nettype wire

// ==== design/cache_hit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_hit
  import cache_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  cache_req_t                     req_i,
  input  cache_tag_t                     core_tag_i,
  input  cache_line_t [`CACHE_WAYS-1:0]  lines_i,
  output cache_rsp_t                     rsp_o,
  output logic                           wr_en_o,
  output cache_way_t                     wr_way_o,
  output cache_idx_t                     wr_idx_o,
  output cache_word_t                    wr_data_o,
  output logic                           touch_en_o,
  output cache_way_t                     touch_way_o
);

  logic [`CACHE_WAYS-1:0] way_hit;
  logic                   hit;
  logic                   advance;
  cache_way_t             hit_way;
  cache_word_t            hit_data;

  logic        ack_q;
  logic        miss_q;
  cache_word_t rdata_q;
  logic        cacheable_q;
  logic        misaligned_q;

  //////////////////////////////////////////////////
  // Tag compare and way select
  //////////////////////////////////////////////////

  // Walk down so the lowest matching way is picked
  always_comb
  begin
    way_hit  = '0;
    hit_way  = '0;
    hit_data = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--)
    begin
      way_hit[w] = lines_i[w].valid && (lines_i[w].tag == core_tag_i);
      if (way_hit[w])
      begin
        hit_way  = cache_way_t'(w);
        hit_data = lines_i[w].data;
      end
    end
  end

  assign hit = |way_hit;

  // Stage moves only without stall
  assign advance = req_i.valid && !stall_i;

  // Write hit, full word into the matching way
  assign wr_en_o   = advance && req_i.we && hit;
  assign wr_way_o  = hit_way;
  assign wr_idx_o  = req_i.adr.f.idx;
  assign wr_data_o = req_i.data;

  // Any hit pushes the other way to victim
  assign touch_en_o  = advance && hit;
  assign touch_way_o = hit_way;

  //////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////

  // Strobes last one cycle, stall drops them
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_q  <= 1'b0;
      miss_q <= 1'b0;
    end
    else if (stall_i)
    begin
      ack_q  <= 1'b0;
      miss_q <= 1'b0;
    end
    else
    begin
      ack_q  <= req_i.valid && hit;
      miss_q <= req_i.valid && !hit;
    end
  end

  // Read word and returned flags
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      rdata_q      <= hit_data;
      cacheable_q  <= req_i.cacheable;
      misaligned_q <= req_i.misaligned;
    end
  end

  always_comb
  begin
    rsp_o.ack        = ack_q;
    rsp_o.miss       = miss_q;
    rsp_o.rdata      = rdata_q;
    rsp_o.cacheable  = cacheable_q;
    rsp_o.misaligned = misaligned_q;
  end

endmodule

`default_nettype wire

// ==== design/cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_memory
  import cache_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  cache_idx_t                     idx_i,
  output cache_line_t [`CACHE_WAYS-1:0]  lines_o,
  output cache_way_t                     lru_way_o,
  input  logic                           fill_i,
  input  cache_adr_u                     fill_adr_i,
  input  cache_word_t                    fill_data_i,
  input  logic                           wr_en_i,
  input  cache_way_t                     wr_way_i,
  input  cache_idx_t                     wr_idx_i,
  input  cache_word_t                    wr_data_i,
  input  logic                           touch_en_i,
  input  cache_way_t                     touch_way_i
);

  // Storage arrays
  cache_tag_t  tag_mem  [`CACHE_WAYS][`CACHE_SETS];
  cache_word_t data_mem [`CACHE_WAYS][`CACHE_SETS];
  logic       [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
  // One LRU entry per set, names the victim way
  cache_way_t [`CACHE_SETS-1:0]                  lru_q;

  cache_idx_t idx_q;
  cache_idx_t fill_idx;
  cache_way_t fill_way;

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Registered index, held while stalled
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
      idx_q <= idx_i;
  end

  // All ways read at the registered index
  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      lines_o[w].valid = valid_q[w][idx_q];
      lines_o[w].tag   = tag_mem[w][idx_q];
      lines_o[w].data  = data_mem[w][idx_q];
    end
  end

  assign lru_way_o = lru_q[idx_q];

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Fill always lands in the victim way of its set
  assign fill_idx = fill_adr_i.f.idx;
  assign fill_way = lru_q[fill_idx];

  // Tag and data words
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      data_mem[wr_way_i][wr_idx_i] <= wr_data_i;
    if (fill_i)
    begin
      tag_mem[fill_way][fill_idx]  <= fill_adr_i.f.tag;
      data_mem[fill_way][fill_idx] <= fill_data_i;
    end
  end

  // Valid and LRU bits
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      // Two ways, so the other way becomes the victim
      if (touch_en_i)
        lru_q[wr_idx_i] <= ~touch_way_i;
      if (fill_i)
      begin
        valid_q[fill_way][fill_idx] <= 1'b1;
        lru_q[fill_idx]             <= ~fill_way;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

`include "cache_params.svh"

  // Basic field types
  typedef logic [`CACHE_XLEN-1:0]      cache_word_t;
  typedef logic [`CACHE_TAG_BITS-1:0]  cache_tag_t;
  typedef logic [`CACHE_IDX_BITS-1:0]  cache_idx_t;
  typedef logic [`CACHE_OFFS_BITS-1:0] cache_offs_t;
  typedef logic [`CACHE_WAY_BITS-1:0]  cache_way_t;

  // Carried with the request, not decoded here
  typedef logic [2:0] cache_size_t;
  typedef logic [2:0] cache_prot_t;

  // Address split, tag on top, byte offset at the bottom
  typedef struct packed {
    cache_tag_t  tag;
    cache_idx_t  idx;
    cache_offs_t offs;
  } cache_adr_fields_t;

  // Same address word, seen raw or as fields
  typedef union packed {
    cache_word_t       raw;
    cache_adr_fields_t f;
  } cache_adr_u;

  // Core request, valid is the strobe
  typedef struct packed {
    logic        valid;
    logic        we;
    cache_adr_u  adr;
    cache_word_t data;
    cache_size_t size;
    cache_prot_t prot;
    logic        lock;
    logic        cacheable;
    logic        misaligned;
  } cache_req_t;

  // Response back to the core
  typedef struct packed {
    logic        ack;
    logic        miss;
    cache_word_t rdata;
    logic        cacheable;
    logic        misaligned;
  } cache_rsp_t;

  // Read-out of one way at one set
  typedef struct packed {
    logic        valid;
    cache_tag_t  tag;
    cache_word_t data;
  } cache_line_t;

endpackage

`default_nettype wire

// ==== design/cache_setup.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_setup
  import cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       stall_i,
  input  logic       flush_i,
  input  cache_req_t req_i,
  output cache_req_t req_o,
  output cache_idx_t idx_o,
  output cache_tag_t core_tag_o
);

  logic       valid_q;
  logic       flush_dly_q;
  cache_req_t req_q;
  cache_idx_t adr_idx;
  cache_idx_t adr_idx_dly_q;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // Valid bit, flush wins over a new request
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q     <= 1'b0;
      flush_dly_q <= 1'b0;
    end
    else
    begin
      flush_dly_q <= flush_i;
      if (flush_i)
        valid_q <= 1'b0;
      else if (!stall_i)
        valid_q <= req_i.valid;
    end
  end

  // Payload follows the request, frozen while stalled
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      req_q      <= req_i;
      // No MMU, tag taken from the virtual address
      core_tag_o <= req_i.adr.f.tag;
    end
  end

  // Hand on payload with the flushable valid bit
  always_comb
  begin
    req_o       = req_q;
    req_o.valid = valid_q;
  end

  //////////////////////////////////////////////////
  // Set index for the memories
  //////////////////////////////////////////////////

  assign adr_idx = req_i.adr.f.idx;

  // Index of the request now sitting in this stage
  always_ff @(posedge clk_i)
  begin
    if (!stall_i || flush_dly_q)
      adr_idx_dly_q <= adr_idx;
  end

  // Memories register this themselves
  // Stalled: repeat the held index, except right after a flush
  assign idx_o = (stall_i && !flush_dly_q) ? adr_idx_dly_q : adr_idx;

endmodule

`default_nettype wire

// ==== include/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////////////////////////
// Base cache geometry
//////////////////////////////////////////////////

// Address and data width of the core
`define CACHE_XLEN 32

// Total capacity in bytes
`define CACHE_SIZE 64

// Associativity, two ways
`define CACHE_WAYS 2

//////////////////////////////////////////////////
// Derived values
//////////////////////////////////////////////////

// One word per block
`define CACHE_BLK_BYTES (`CACHE_XLEN / 8)

// Sets per way, 64 / (4 * 2) = 8
`define CACHE_SETS (`CACHE_SIZE / (`CACHE_BLK_BYTES * `CACHE_WAYS))

// Byte offset inside a block
`define CACHE_OFFS_BITS ($clog2(`CACHE_BLK_BYTES))

// Set index, sits right above the offset
`define CACHE_IDX_BITS ($clog2(`CACHE_SETS))

// Remaining upper address bits
`define CACHE_TAG_BITS (`CACHE_XLEN - `CACHE_IDX_BITS - `CACHE_OFFS_BITS)

// Way number width
`define CACHE_WAY_BITS ($clog2(`CACHE_WAYS))

`endif

// ==== verification/cache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_assertions
  import cache_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       stall_i,
  input logic       flush_i,
  input cache_req_t req_i,
  input cache_req_t stage_req_i,
  input logic       fill_i,
  input cache_rsp_t rsp_i
);

  // Running count of failed properties
  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // Response strobes
  //////////////////////////////////////////////////

  // Hit and miss exclude each other
  ack_miss_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rsp_i.ack && rsp_i.miss))
  else
  begin
    fail_cnt++;
    $error("ack and miss high in the same cycle");
  end

  // First edge out of reset sees both strobes low
  rsp_after_rst: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!rsp_i.ack && !rsp_i.miss))
  else
  begin
    fail_cnt++;
    $error("response strobe high right after reset");
  end

  // Request accepted at N and unstalled at N+1 gives one strobe at N+2
  one_rsp_per_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.valid && !stall_i && !flush_i) ##1 !stall_i |=> (rsp_i.ack != rsp_i.miss))
  else
  begin
    fail_cnt++;
    $error("accepted request got no single ack or miss");
  end

  //////////////////////////////////////////////////
  // Fill port
  //////////////////////////////////////////////////

  // Fill only with the pipeline empty
  fill_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i |-> !stage_req_i.valid)
  else
  begin
    fail_cnt++;
    $error("fill strobe while a request is in flight");
  end

endmodule

// Attached to every cache_core
bind cache_core cache_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .stall_i     (stall_i),
  .flush_i     (flush_i),
  .req_i       (req_i),
  .stage_req_i (stage_req),
  .fill_i      (fill_i),
  .rsp_i       (rsp_o)
);

`default_nettype wire

// ==== verification/cache_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, low at time zero
  initial
  begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial
  begin
    rst_no = 1'b0;
    #(period_ns * rst_cycles);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int clk_period = 20;
  localparam int dir_ops    = 60;
  localparam int stream_ops = 48;
  // Ten cycles per operation, plus reset and drain
  localparam int timeout_cycles = (dir_ops + stream_ops) * 10 + 16 + 100;

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic        flush;
  logic        fill;
  cache_adr_u  fill_adr;
  cache_word_t fill_data;
  cache_req_t  req;
  cache_rsp_t  rsp;

  // Shadow copy of valid, tag, data and LRU
  logic        m_valid [`CACHE_WAYS][`CACHE_SETS];
  cache_tag_t  m_tag   [`CACHE_WAYS][`CACHE_SETS];
  cache_word_t m_data  [`CACHE_WAYS][`CACHE_SETS];
  cache_way_t  m_lru   [`CACHE_SETS];
  // Request sitting in the setup register
  cache_req_t  m_slot;

  // Expected response for the edge just past
  logic        exp_ack;
  logic        exp_miss;
  logic        exp_read;
  cache_word_t exp_rdata;
  logic        exp_cacheable;
  logic        exp_misaligned;

  int          error_cnt;
  cache_adr_u  known_adrs [$];

  cache_clk_gen #(
    .period_ns  (clk_period),
    .rst_cycles (16)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  cache_core DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .stall_i     (stall),
    .flush_i     (flush),
    .req_i       (req),
    .fill_i      (fill),
    .fill_adr_i  (fill_adr),
    .fill_data_i (fill_data),
    .rsp_o       (rsp)
  );

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic cache_tag_t rand_tag();
    return cache_tag_t'($urandom);
  endfunction

  function automatic cache_adr_u make_adr(input cache_tag_t tag, input cache_idx_t idx);
    cache_adr_u a;
    a.f.tag  = tag;
    a.f.idx  = idx;
    a.f.offs = cache_offs_t'($urandom);
    return a;
  endfunction

  // Full-word access, size and prot only ride along
  function automatic cache_req_t make_req(input logic we, input cache_adr_u adr,
                                          input cache_word_t data);
    cache_req_t r;
    r            = '0;
    r.valid      = 1'b1;
    r.we         = we;
    r.adr        = adr;
    r.data       = data;
    r.size       = 3'b010;
    r.prot       = cache_prot_t'($urandom);
    r.cacheable  = 1'($urandom);
    r.misaligned = 1'($urandom);
    return r;
  endfunction

  // Mostly known lines, some cold addresses, a quarter writes
  function automatic cache_req_t stream_req();
    cache_adr_u adr;
    logic       we;
    if ($urandom % 4 == 0)
      adr = make_adr(rand_tag(), cache_idx_t'($urandom));
    else
      adr = known_adrs[$urandom % known_adrs.size()];
    we = ($urandom % 4 == 0);
    return make_req(we, adr, $urandom);
  endfunction

  //////////////////////////////////////////////////
  // Shadow model and checks
  //////////////////////////////////////////////////

  // One rising edge, with the inputs held across it
  task automatic model_edge();
    cache_idx_t s;
    cache_idx_t fs;
    int         way;
    logic       hit;
    exp_ack  = 1'b0;
    exp_miss = 1'b0;
    // Hit stage works on the held request
    if (!stall && m_slot.valid)
    begin
      s   = m_slot.adr.f.idx;
      hit = 1'b0;
      way = 0;
      for (int w = `CACHE_WAYS - 1; w >= 0; w--)
      begin
        if (m_valid[w][s] && m_tag[w][s] == m_slot.adr.f.tag)
        begin
          hit = 1'b1;
          way = w;
        end
      end
      exp_ack        = hit;
      exp_miss       = !hit;
      exp_read       = !m_slot.we;
      exp_rdata      = m_data[way][s];
      exp_cacheable  = m_slot.cacheable;
      exp_misaligned = m_slot.misaligned;
      if (hit && m_slot.we)
        m_data[way][s] = m_slot.data;
      // Other way turns victim
      if (hit)
        m_lru[s] = cache_way_t'(1 - way);
    end
    // Fill replaces the LRU way of its set
    if (fill)
    begin
      fs               = fill_adr.f.idx;
      way              = m_lru[fs];
      m_valid[way][fs] = 1'b1;
      m_tag[way][fs]   = fill_adr.f.tag;
      m_data[way][fs]  = fill_data;
      m_lru[fs]        = cache_way_t'(1 - way);
    end
    if (!stall)
      m_slot = req;
    // Flush drops whatever entered setup
    if (flush)
      m_slot.valid = 1'b0;
  endtask

  task automatic check_field(input string name, input cache_word_t exp_val,
                             input cache_word_t act_val);
    assert (act_val === exp_val)
    else
    begin
      error_cnt++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_rsp();
    check_field("rsp_o.ack", exp_ack, rsp.ack);
    check_field("rsp_o.miss", exp_miss, rsp.miss);
    if (exp_ack || exp_miss)
    begin
      check_field("rsp_o.cacheable", exp_cacheable, rsp.cacheable);
      check_field("rsp_o.misaligned", exp_misaligned, rsp.misaligned);
    end
    // Data only counts on a read hit
    if (exp_ack && exp_read)
      check_field("rsp_o.rdata", exp_rdata, rsp.rdata);
  endtask

  // Inputs change on the falling edge only
  task automatic tick();
    @(posedge clk);
    @(negedge clk);
    model_edge();
    check_rsp();
  endtask

  // Request held through the stall, accepted on the last edge
  task automatic issue(input cache_req_t r, input int stall_cycles);
    req   = r;
    stall = 1'b1;
    repeat (stall_cycles) tick();
    stall = 1'b0;
    tick();
  endtask

  task automatic idle_cycles(input int n);
    req.valid = 1'b0;
    repeat (n) tick();
  endtask

  // Setup drains first, fill sees an empty pipe
  task automatic fill_line(input cache_adr_u adr, input cache_word_t data);
    idle_cycles(1);
    fill      = 1'b1;
    fill_adr  = adr;
    fill_data = data;
    tick();
    fill = 1'b0;
    known_adrs.push_back(adr);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    cache_adr_u a [4];
    cache_adr_u b;
    cache_adr_u evict_adr [3];
    cache_tag_t t;
    void'($urandom(32'hc90));
    req       = '0;
    stall     = 1'b0;
    flush     = 1'b0;
    fill      = 1'b0;
    fill_adr  = '0;
    fill_data = '0;
    error_cnt = 0;
    m_slot    = '0;
    for (int s = 0; s < `CACHE_SETS; s++)
    begin
      m_lru[s] = '0;
      for (int w = 0; w < `CACHE_WAYS; w++)
        m_valid[w][s] = 1'b0;
    end
    @(posedge rst_n);

    // Cold cache, back-to-back reads all miss
    for (int i = 0; i < `CACHE_SETS; i++)
      issue(make_req(1'b0, make_adr(rand_tag(), cache_idx_t'(i)), '0), 0);

    // Fill four sets, then read them back
    for (int i = 0; i < 4; i++)
    begin
      a[i] = make_adr(rand_tag(), cache_idx_t'(i));
      fill_line(a[i], $urandom);
    end
    idle_cycles(1);
    for (int i = 0; i < 4; i++)
      issue(make_req(1'b0, a[i], '0), 0);

    // Write hit then read, write miss leaves the set alone
    issue(make_req(1'b1, a[1], $urandom), 0);
    issue(make_req(1'b0, a[1], '0), 0);
    b = make_adr(a[1].f.tag ^ cache_tag_t'(1), cache_idx_t'(1));
    issue(make_req(1'b1, b, $urandom), 0);
    issue(make_req(1'b0, b, '0), 0);
    issue(make_req(1'b0, a[1], '0), 0);

    // Two tags share set 5, a third evicts the LRU one
    t = rand_tag();
    for (int k = 0; k < 3; k++)
      evict_adr[k] = make_adr(t ^ cache_tag_t'(k), cache_idx_t'(5));
    fill_line(evict_adr[0], $urandom);
    fill_line(evict_adr[1], $urandom);
    idle_cycles(1);
    issue(make_req(1'b0, evict_adr[1], '0), 0);
    issue(make_req(1'b0, evict_adr[0], '0), 0);
    fill_line(evict_adr[2], $urandom);
    idle_cycles(1);
    for (int k = 0; k < 3; k++)
      issue(make_req(1'b0, evict_adr[k], '0), 0);

    // Second request entering with flush is dropped
    issue(make_req(1'b0, a[0], '0), 0);
    flush = 1'b1;
    issue(make_req(1'b0, a[2], '0), 0);
    flush = 1'b0;
    idle_cycles(2);

    // Random stream, one long stall halfway
    for (int i = 0; i < stream_ops; i++)
      issue(stream_req(), (i == stream_ops / 2) ? 4 : (($urandom % 8 == 0) ? 1 : 0));
    idle_cycles(3);

    $display("Checks done: %0d response errors, %0d assertion failures",
             error_cnt, DUT.u_assertions.fail_cnt);
    if (error_cnt == 0 && DUT.u_assertions.fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
